//--- rotary_settings.svh
`ifndef ROTARY_SETTINGS_SVH
`define ROTARY_SETTINGS_SVH

`default_nettype none

// instruction word
`define ROTARY_INST_WIDTH 12

// opcode sits in the top nibble
`define ROTARY_OPCODE_MSB 11
`define ROTARY_OPCODE_LSB 8

// equal samples needed before a pin change is accepted
`define ROTARY_DEBOUNCE_CYCLES 4

`default_nettype wire

`endif

//--- rotary_pkg.sv
`include "rotary_settings.svh"

`default_nettype none

package rotary_pkg;

   localparam int ROTARY_OPCODE_WIDTH = `ROTARY_OPCODE_MSB - `ROTARY_OPCODE_LSB + 1;

   // encoder channels within rotary_pins_t
   localparam int ROTARY_PIN_A = 0;
   localparam int ROTARY_PIN_B = 1;

   typedef logic [`ROTARY_INST_WIDTH-1:0] rotary_inst_t;

   typedef logic [1:0] rotary_pins_t;   // bit 0 channel a, bit 1 channel b

   typedef enum logic [ROTARY_OPCODE_WIDTH-1:0] {
      ROTARY_NOP  = 4'h0,
      ROTARY_RDLS = 4'h1,   // read and clear left flag
      ROTARY_RDRS = 4'h2    // read and clear right flag
   } rotary_opcode_e;

   typedef enum logic [1:0] {
      ROTARY_STATE_RESET = 2'h0,
      ROTARY_STATE_READY = 2'h1,
      ROTARY_STATE_ERROR = 2'h2
   } rotary_state_e;

endpackage

`default_nettype wire

//--- rotary_debounce.sv
`include "rotary_settings.svh"

`default_nettype none

module rotary_debounce #(
   parameter int STABLE_CYCLES = `ROTARY_DEBOUNCE_CYCLES
) (
   input  logic clock,
   input  logic reset,
   input  logic pin,
   output logic level
);

   localparam int COUNT_WIDTH = $clog2(STABLE_CYCLES + 1);
   localparam logic [COUNT_WIDTH-1:0] COUNT_LAST = COUNT_WIDTH'(STABLE_CYCLES);

   logic                   sync_meta;   // first stage, may go metastable
   logic                   sync_pin;
   logic [COUNT_WIDTH-1:0] count;
   logic [COUNT_WIDTH-1:0] count_next;
   logic                   differs;

   // pin is asynchronous to clock
   always_ff @(posedge clock) begin
      if (reset) begin
         sync_meta <= 1'b0;
         sync_pin  <= 1'b0;
      end else begin
         sync_meta <= pin;
         sync_pin  <= sync_meta;
      end
   end

   assign differs    = sync_pin != level;
   assign count_next = count + 1'b1;

   // level only moves after an unbroken run of differing samples
   always_ff @(posedge clock) begin
      if (reset) begin
         count <= '0;
         level <= 1'b0;
      end else if (!differs) begin
         count <= '0;             // run broken, start over
      end else if (count_next == COUNT_LAST) begin
         count <= '0;
         level <= sync_pin;       // accept new value
      end else begin
         count <= count_next;
      end
   end

endmodule

`default_nettype wire

//--- rotary_interface.sv
`include "rotary_settings.svh"

`default_nettype none

module rotary_interface #(
   parameter int STABLE_CYCLES = `ROTARY_DEBOUNCE_CYCLES
) (
   input  logic                      clock,
   input  logic                      reset,
   input  rotary_pkg::rotary_pins_t  rotary,
   output logic                      rotary_left,
   output logic                      rotary_right
);

   import rotary_pkg::*;

   rotary_pins_t levels;       // debounced pins
   logic         level_a_prev;
   logic         rise_a;

   for (genvar i = 0; i < $bits(rotary_pins_t); i++) begin : g_debounce
      rotary_debounce #(
         .STABLE_CYCLES (STABLE_CYCLES)
      ) rotary_debounce_i (
         .clock (clock),
         .reset (reset),
         .pin   (rotary[i]),
         .level (levels[i])
      );
   end

   assign rise_a = levels[ROTARY_PIN_A] & ~level_a_prev;

   // b sampled at the rising edge of a gives the direction
   always_ff @(posedge clock) begin
      if (reset) begin
         level_a_prev <= 1'b0;
         rotary_left  <= 1'b0;
         rotary_right <= 1'b0;
      end else begin
         level_a_prev <= levels[ROTARY_PIN_A];
         rotary_left  <= rise_a &  levels[ROTARY_PIN_B];   // b high
         rotary_right <= rise_a & ~levels[ROTARY_PIN_B];   // b low
      end
   end

endmodule

`default_nettype wire

//--- rotary_device.sv
`include "rotary_settings.svh"

`default_nettype none

module rotary_device (
   input  logic                      clock,
   input  logic                      reset,
   input  rotary_pkg::rotary_inst_t  inst,
   input  logic                      inst_en,
   input  rotary_pkg::rotary_pins_t  rotary,
   output logic                      rotary_left_status,
   output logic                      rotary_right_status
);

   import rotary_pkg::*;

   rotary_state_e  state;
   rotary_state_e  state_next;
   rotary_opcode_e opcode;

   logic rotary_left;          // one-cycle turn pulses
   logic rotary_right;
   logic left_flag;            // sticky, set by a turn
   logic right_flag;
   logic left_flag_next;
   logic right_flag_next;
   logic left_status_next;
   logic right_status_next;

   assign opcode = rotary_opcode_e'(inst[`ROTARY_OPCODE_MSB:`ROTARY_OPCODE_LSB]);

   rotary_interface rotary_interface_i (
      .clock        (clock),
      .reset        (reset),
      .rotary       (rotary),
      .rotary_left  (rotary_left),
      .rotary_right (rotary_right)
   );

   always_comb begin
      state_next        = state;
      left_flag_next    = left_flag | rotary_left;
      right_flag_next   = right_flag | rotary_right;
      left_status_next  = rotary_left_status;
      right_status_next = rotary_right_status;

      case (state)
         ROTARY_STATE_RESET: begin
            state_next        = ROTARY_STATE_READY;
            left_flag_next    = 1'b0;
            right_flag_next   = 1'b0;
            left_status_next  = 1'b0;
            right_status_next = 1'b0;
         end

         ROTARY_STATE_READY: begin
            if (inst_en) begin
               case (opcode)
                  ROTARY_NOP: begin
                  end

                  ROTARY_RDLS: begin
                     left_status_next = left_flag;
                     left_flag_next   = rotary_left;   // keep a turn seen during the read
                  end

                  ROTARY_RDRS: begin
                     right_status_next = right_flag;
                     right_flag_next   = rotary_right;
                  end

                  default: begin
                     state_next        = ROTARY_STATE_ERROR;   // illegal opcode
                     left_flag_next    = 1'b0;
                     right_flag_next   = 1'b0;
                     left_status_next  = 1'b0;
                     right_status_next = 1'b0;
                  end
               endcase
            end
         end

         default: begin
            // error holds until reset
            state_next        = ROTARY_STATE_ERROR;
            left_flag_next    = 1'b0;
            right_flag_next   = 1'b0;
            left_status_next  = 1'b0;
            right_status_next = 1'b0;
         end
      endcase
   end

   always_ff @(posedge clock) begin
      if (reset) begin
         state               <= ROTARY_STATE_RESET;
         left_flag           <= 1'b0;
         right_flag          <= 1'b0;
         rotary_left_status  <= 1'b0;
         rotary_right_status <= 1'b0;
      end else begin
         state               <= state_next;
         left_flag           <= left_flag_next;
         right_flag          <= right_flag_next;
         rotary_left_status  <= left_status_next;
         rotary_right_status <= right_status_next;
      end
   end

endmodule

`default_nettype wire

//--- rotary_top.sv
`default_nettype none

module rotary_top (
   input  logic                      clock,
   input  logic                      reset,
   input  rotary_pkg::rotary_inst_t  inst,
   input  logic                      inst_en,
   input  rotary_pkg::rotary_pins_t  rotary,
   output logic                      rotary_left_status,
   output logic                      rotary_right_status
);

   import rotary_pkg::*;

   rotary_pins_t rotary_pins;   // raw encoder pins
   rotary_inst_t rotary_inst;

   assign rotary_pins = rotary;
   assign rotary_inst = inst;

   rotary_device rotary_device_i (
      .clock               (clock),
      .reset               (reset),
      .inst                (rotary_inst),
      .inst_en             (inst_en),
      .rotary              (rotary_pins),
      .rotary_left_status  (rotary_left_status),
      .rotary_right_status (rotary_right_status)
   );

endmodule

`default_nettype wire

//--- rotary_checker.sv
`default_nettype none

module rotary_checker (
   input  logic                       clock,
   input  logic                       reset,
   input  rotary_pkg::rotary_state_e  state,
   input  logic                       inst_en,
   input  logic                       rotary_left_status,
   input  logic                       rotary_right_status
);

   timeunit 1ns;
   timeprecision 1ps;

   import rotary_pkg::*;

   int assert_failures = 0;   // read by the testbench at the end

   no_reset_reentry: assert property (@(posedge clock) disable iff (reset)
      !$past(reset) |-> state != ROTARY_STATE_RESET)
   else begin
      assert_failures++;
      $error("device returned to RESET state without reset");
   end

   error_sticky: assert property (@(posedge clock) disable iff (reset)
      state == ROTARY_STATE_ERROR |=> state == ROTARY_STATE_ERROR)
   else begin
      assert_failures++;
      $error("device left ERROR state without reset");
   end

   error_outputs_low: assert property (@(posedge clock) disable iff (reset)
      state == ROTARY_STATE_ERROR |-> !rotary_left_status && !rotary_right_status)
   else begin
      assert_failures++;
      $error("status outputs not zero in ERROR state");
   end

   // outputs only move on the edge that takes an instruction
   status_hold: assert property (@(posedge clock) disable iff (reset)
      !$past(inst_en) |-> $stable(rotary_left_status) && $stable(rotary_right_status))
   else begin
      assert_failures++;
      $error("status output changed without an instruction strobe");
   end

endmodule

`default_nettype wire

//--- tb_rotary_top.sv
`include "rotary_settings.svh"

`default_nettype none

module tb_rotary_top;

   timeunit 1ns;
   timeprecision 1ps;

   import rotary_pkg::*;

   localparam int STEP_CYCLES   = `ROTARY_DEBOUNCE_CYCLES + 4;   // hold per gray step
   localparam int RESET_CYCLES  = 16;
   localparam int SETTLE_CYCLES = 12;
   localparam int MAX_CYCLES    = 3000;   // several times the summed test length

   logic         clock;
   logic         reset;
   rotary_inst_t inst;
   logic         inst_en;
   rotary_pins_t rotary;
   logic         rotary_left_status;
   logic         rotary_right_status;

   integer seed;
   int     cycle_count = 0;
   int     error_count;
   int     tests_passed;
   int     tests_failed;
   int     assert_count;

   // expected device state
   logic model_left;
   logic model_right;
   logic model_error;
   logic exp_left_status;
   logic exp_right_status;

   rotary_top rotary_top_i (
      .clock               (clock),
      .reset               (reset),
      .inst                (inst),
      .inst_en             (inst_en),
      .rotary              (rotary),
      .rotary_left_status  (rotary_left_status),
      .rotary_right_status (rotary_right_status)
   );

   bind rotary_device rotary_checker rotary_checker_i (
      .clock               (clock),
      .reset               (reset),
      .state               (state),
      .inst_en             (inst_en),
      .rotary_left_status  (rotary_left_status),
      .rotary_right_status (rotary_right_status)
   );

   initial begin
      clock = 1'b0;
      forever #5 clock = ~clock;
   end

   always @(posedge clock) begin
      cycle_count++;
      if (cycle_count >= MAX_CYCLES) begin
         $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
         $display("Testbench failed");
         $finish;
      end
   end

   task automatic check_status(input string name, input logic actual, input logic expected);
      if (actual !== expected) begin
         $display("[FAIL] %s: got 0x%h, expected 0x%h", name, actual, expected);
         error_count++;
      end
   endtask

   task automatic clear_model();
      model_left       = 1'b0;
      model_right      = 1'b0;
      model_error      = 1'b0;
      exp_left_status  = 1'b0;
      exp_right_status = 1'b0;
   endtask

   task automatic apply_reset();
      @(negedge clock);
      reset   = 1'b1;
      inst_en = 1'b0;
      inst    = '0;
      rotary  = '0;
      repeat (RESET_CYCLES) @(negedge clock);
      reset = 1'b0;
      clear_model();
      repeat (2) @(negedge clock);   // device passes through RESET
   endtask

   // one detent in gray code, pins given as {b, a}
   task automatic turn(input logic left);
      rotary_pins_t steps [4];
      if (left)
         steps = '{2'b10, 2'b11, 2'b01, 2'b00};   // a rises with b high
      else
         steps = '{2'b01, 2'b11, 2'b10, 2'b00};   // a rises with b low
      for (int i = 0; i < 4; i++) begin
         rotary = steps[i];
         repeat (STEP_CYCLES) @(negedge clock);
      end
      if (!model_error) begin
         if (left)
            model_left = 1'b1;
         else
            model_right = 1'b1;
      end
   endtask

   task automatic glitch_a();
      rotary = 2'b01;
      repeat (2) @(negedge clock);   // shorter than the debounce window
      rotary = 2'b00;
      repeat (SETTLE_CYCLES) @(negedge clock);
   endtask

   // one instruction strobe, then both status outputs checked
   task automatic issue(input logic [ROTARY_OPCODE_WIDTH-1:0] opcode);
      logic [31:0] rnd;
      rnd = $random(seed);
      inst = '0;
      inst[`ROTARY_OPCODE_MSB:`ROTARY_OPCODE_LSB] = opcode;
      inst[`ROTARY_OPCODE_LSB-1:0] = rnd[`ROTARY_OPCODE_LSB-1:0];   // operand is ignored
      inst_en = 1'b1;
      if (!model_error) begin
         case (opcode)
            ROTARY_NOP: begin
            end
            ROTARY_RDLS: begin
               exp_left_status = model_left;
               model_left      = 1'b0;
            end
            ROTARY_RDRS: begin
               exp_right_status = model_right;
               model_right      = 1'b0;
            end
            default: begin
               model_error      = 1'b1;
               model_left       = 1'b0;
               model_right      = 1'b0;
               exp_left_status  = 1'b0;
               exp_right_status = 1'b0;
            end
         endcase
      end
      @(negedge clock);
      inst_en = 1'b0;
      inst    = '0;
      check_status("rotary_left_status", rotary_left_status, exp_left_status);
      check_status("rotary_right_status", rotary_right_status, exp_right_status);
   endtask

   task automatic finish_test(input string name, input int errors_before);
      if (error_count == errors_before) begin
         tests_passed++;
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: %0d errors", name, error_count - errors_before);
      end
   endtask

   task automatic test_quiet_read();
      int errors_before;
      errors_before = error_count;
      issue(ROTARY_RDLS);
      issue(ROTARY_RDRS);
      finish_test("quiet_read", errors_before);
   endtask

   task automatic test_right_turn();
      int errors_before;
      errors_before = error_count;
      turn(1'b0);
      issue(ROTARY_RDRS);
      issue(ROTARY_RDRS);   // flag was cleared by the first read
      finish_test("right_turn", errors_before);
   endtask

   task automatic test_left_turns();
      int errors_before;
      errors_before = error_count;
      repeat (3) turn(1'b1);
      issue(ROTARY_RDLS);
      issue(ROTARY_RDLS);
      finish_test("left_turns", errors_before);
   endtask

   task automatic test_glitch_nop();
      int errors_before;
      errors_before = error_count;
      glitch_a();
      issue(ROTARY_NOP);
      issue(ROTARY_RDLS);
      issue(ROTARY_RDRS);
      turn(1'b1);
      issue(ROTARY_NOP);
      turn(1'b0);
      issue(ROTARY_NOP);
      issue(ROTARY_RDLS);
      issue(ROTARY_RDRS);
      finish_test("glitch_nop", errors_before);
   endtask

   task automatic test_error_state();
      int errors_before;
      errors_before = error_count;
      turn(1'b0);
      issue(4'h7);   // illegal opcode
      turn(1'b1);
      issue(ROTARY_RDLS);
      issue(ROTARY_RDRS);
      apply_reset();
      turn(1'b1);
      issue(ROTARY_RDLS);
      issue(ROTARY_RDRS);
      finish_test("error_state", errors_before);
   endtask

   initial begin
      reset        = 1'b1;
      inst         = '0;
      inst_en      = 1'b0;
      rotary       = '0;
      seed         = 22;
      error_count  = 0;
      tests_passed = 0;
      tests_failed = 0;
      clear_model();

      apply_reset();
      test_quiet_read();
      test_right_turn();
      test_left_turns();
      test_glitch_nop();
      test_error_state();

      assert_count = rotary_top_i.rotary_device_i.rotary_checker_i.assert_failures;
      if (assert_count != 0) begin
         $display("device checker reported %0d assertion failures", assert_count);
         error_count += assert_count;
      end
      $display("%0d tests passed, %0d tests failed, %0d errors",
               tests_passed, tests_failed, error_count);
      if (error_count == 0 && tests_failed == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- rotary_top.f
+incdir+.
rotary_pkg.sv
rotary_debounce.sv
rotary_interface.sv
rotary_device.sv
rotary_top.sv
rotary_checker.sv
tb_rotary_top.sv

//--- Makefile
TOP := tb_rotary_top
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f rotary_top.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	@grep -qx "Testbench passed" $(LOG) || (echo "simulation FAILED"; exit 1)

lint:
	verilator --lint-only --timing --timescale 1ns/1ps \
		-f rotary_top.f --top-module rotary_top

clean:
	rm -rf obj_dir $(LOG)
